/* Makefile */
TOP = tb_hook_swing

.PHONY: all build lint clean

# build, run, and fail unless the pass line shows up
all: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TB PASSED"

build:
	verilator --binary --assert -Wno-fatal -f verilog.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -Wall -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* src/grab_detector.sv */
`timescale 1ns/1ps
`default_nettype none

module grab_detector import hook_pkg::*; (
	input  logic [NUM_TARGETS-1:0] catch_hit,
	input  logic [NUM_TARGETS-1:0] target_gone,
	output logic                   grab,
	output weight_t                grab_weight
);

	logic [NUM_TARGETS-1:0]         live_hit;
	logic [$clog2(NUM_TARGETS)-1:0] grab_idx;

	// a target already taken cannot be caught again
	assign live_hit = catch_hit & ~target_gone;
	assign grab = |live_hit;

	//////////////////////////////////////////////////////////////////////
	// lowest index wins

	always_comb begin
		grab_idx = '0;
		for (int i = NUM_TARGETS - 1; i >= 0; i--) begin
			if (live_hit[i]) begin
				grab_idx = i[$clog2(NUM_TARGETS)-1:0];
			end
		end
	end

	always_comb begin
		if (grab) begin
			grab_weight = TARGET_WEIGHT[grab_idx];
		end else begin
			grab_weight = WEIGHT_NONE;
		end
	end

endmodule

`default_nettype wire

/* src/hook_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module hook_fsm import hook_pkg::*; (
	input  logic        Clk,
	input  logic        reset,
	input  logic        restart,
	input  logic        extend,
	input  logic        at_bound,
	input  logic        grab,
	input  logic        at_rest,
	output hook_state_t state
);

	hook_state_t next_state;

	always_ff @(posedge Clk) begin
		if (reset || restart) begin
			state <= SWING;
		end else begin
			state <= next_state;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// next state

	always_comb begin
		next_state = state;
		case (state)
			SWING: begin
				// button down freezes the aim
				if (extend) begin
					next_state = AIM;
				end
			end
			AIM: begin
				// fire on release
				if (!extend) begin
					next_state = EXTEND;
				end
			end
			EXTEND: begin
				if (at_bound || grab) begin
					next_state = RETRACT;
				end
			end
			RETRACT: begin
				if (at_rest) begin
					next_state = SWING;
				end
			end
			default: begin
				next_state = SWING;
			end
		endcase
	end

	state_legal: assert property (@(posedge Clk) disable iff (reset || restart)
		state inside {SWING, AIM, EXTEND, RETRACT});

endmodule

`default_nettype wire

/* src/hook_pkg.sv */
`default_nettype none

package hook_pkg;

	//////////////////////////////////////////////////////////////////////
	// types

	typedef enum logic [2:0] {
		SWING,
		AIM,
		EXTEND,
		RETRACT
	} hook_state_t;

	typedef enum logic [1:0] {
		WEIGHT_NONE,
		WEIGHT_LIGHT,
		WEIGHT_MEDIUM,
		WEIGHT_HEAVY
	} weight_t;

	typedef logic [9:0] coord_t;
	typedef logic [3:0] angle_t;
	typedef logic [9:0] reach_t;

	//////////////////////////////////////////////////////////////////////
	// screen geometry

	localparam int NUM_TARGETS = 14;
	localparam angle_t ANGLE_MAX = 4'd10;

	// string head, fixed
	localparam coord_t HEAD_X = 10'd430;
	localparam coord_t HEAD_Y = 10'd70;

	// play field
	localparam coord_t BOUND_LEFT = 10'd40;
	localparam coord_t BOUND_RIGHT = 10'd620;
	localparam coord_t BOUND_BOTTOM = 10'd460;

	// tail step per reach unit, left sweep end to right sweep end
	localparam logic signed [3:0] DIR_X [0:ANGLE_MAX] = '{
		-4'sd6, -4'sd6, -4'sd5, -4'sd4, -4'sd2, 4'sd0,
		4'sd2, 4'sd4, 4'sd5, 4'sd6, 4'sd6
	};
	localparam logic signed [3:0] DIR_Y [0:ANGLE_MAX] = '{
		4'sd0, 4'sd1, 4'sd2, 4'sd3, 4'sd4, 4'sd6,
		4'sd4, 4'sd3, 4'sd2, 4'sd1, 4'sd0
	};

	// catch class per target, sets the retract speed
	localparam weight_t TARGET_WEIGHT [0:NUM_TARGETS-1] = '{
		WEIGHT_HEAVY, WEIGHT_HEAVY, WEIGHT_MEDIUM, WEIGHT_MEDIUM,
		WEIGHT_LIGHT, WEIGHT_LIGHT, WEIGHT_HEAVY, WEIGHT_HEAVY,
		WEIGHT_LIGHT, WEIGHT_LIGHT, WEIGHT_HEAVY, WEIGHT_HEAVY,
		WEIGHT_LIGHT, WEIGHT_LIGHT
	};

endpackage

`default_nettype wire

/* src/hook_swing_top.sv */
`timescale 1ns/1ps
`default_nettype none

module hook_swing_top import hook_pkg::*; #(
	parameter logic [31:0] TICK_PERIOD = 32'd8000000
) (
	input  logic                   Clk,
	input  logic                   reset,
	input  logic                   restart,
	input  logic                   extend,
	input  logic [NUM_TARGETS-1:0] catch_hit,
	input  logic [NUM_TARGETS-1:0] target_gone,
	output hook_state_t            state,
	output angle_t                 angle,
	output reach_t                 reach,
	output coord_t                 tail_x,
	output coord_t                 tail_y,
	output logic                   at_bound
);

	logic    grab;
	logic    at_rest;
	weight_t grab_weight;

	//////////////////////////////////////////////////////////////////////
	// control

	hook_fsm u_fsm (
		.Clk      (Clk),
		.reset    (reset),
		.restart  (restart),
		.extend   (extend),
		.at_bound (at_bound),
		.grab     (grab),
		.at_rest  (at_rest),
		.state    (state)
	);

	swing_timer #(.TICK_PERIOD(TICK_PERIOD)) u_swing (
		.Clk     (Clk),
		.reset   (reset),
		.restart (restart),
		.state   (state),
		.angle   (angle)
	);

	grab_detector u_grab (
		.catch_hit   (catch_hit),
		.target_gone (target_gone),
		.grab        (grab),
		.grab_weight (grab_weight)
	);

	//////////////////////////////////////////////////////////////////////
	// string length and tail

	reach_counter #(.TICK_PERIOD(TICK_PERIOD)) u_reach (
		.Clk         (Clk),
		.reset       (reset),
		.restart     (restart),
		.state       (state),
		.grab_weight (grab_weight),
		.reach       (reach),
		.at_rest     (at_rest)
	);

	tail_position u_tail (
		.Clk      (Clk),
		.reset    (reset),
		.restart  (restart),
		.angle    (angle),
		.reach    (reach),
		.tail_x   (tail_x),
		.tail_y   (tail_y),
		.at_bound (at_bound)
	);

endmodule

`default_nettype wire

/* src/reach_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module reach_counter import hook_pkg::*; #(
	parameter logic [31:0] TICK_PERIOD = 32'd8000000
) (
	input  logic        Clk,
	input  logic        reset,
	input  logic        restart,
	input  hook_state_t state,
	input  weight_t     grab_weight,
	output reach_t      reach,
	output logic        at_rest
);

	localparam logic [31:0] FULL_STEP = TICK_PERIOD;
	localparam logic [31:0] HALF_STEP = TICK_PERIOD / 2;
	localparam logic [31:0] QUARTER_STEP = TICK_PERIOD / 4;

	logic [31:0] sub_count;
	logic [31:0] retract_limit;
	weight_t     held_weight;

	// heavier catch, slower pull
	always_comb begin
		case (held_weight)
			WEIGHT_HEAVY:  retract_limit = FULL_STEP;
			WEIGHT_MEDIUM: retract_limit = HALF_STEP;
			default:       retract_limit = QUARTER_STEP;
		endcase
	end

	assign at_rest = (reach == '0);

	//////////////////////////////////////////////////////////////////////
	// step counter

	always_ff @(posedge Clk) begin
		if (reset || restart) begin
			sub_count <= '0;
			reach <= '0;
			held_weight <= WEIGHT_NONE;
		end else begin
			case (state)
				EXTEND: begin
					held_weight <= grab_weight;
					if (sub_count >= HALF_STEP) begin
						sub_count <= '0;
						reach <= reach + 10'd1;
					end else begin
						sub_count <= sub_count + 32'd1;
					end
				end
				RETRACT: begin
					// sub_count carries over from extension and may already be past the limit
					if (sub_count >= retract_limit) begin
						sub_count <= '0;
						if (!at_rest) begin
							reach <= reach - 10'd1;
						end
					end else begin
						sub_count <= sub_count + 32'd1;
					end
				end
				default: begin
					sub_count <= '0;
					reach <= '0;
				end
			endcase
		end
	end

	no_underflow: assert property (@(posedge Clk) disable iff (reset || restart)
		(state == RETRACT) |=> (reach <= $past(reach)));

endmodule

`default_nettype wire

/* src/swing_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module swing_timer import hook_pkg::*; #(
	parameter logic [31:0] TICK_PERIOD = 32'd8000000
) (
	input  logic        Clk,
	input  logic        reset,
	input  logic        restart,
	input  hook_state_t state,
	output angle_t      angle
);

	logic [31:0] tick_count;
	logic        tick;
	logic        sweep_up;

	// one tick every TICK_PERIOD+1 cycles
	assign tick = (tick_count == TICK_PERIOD);

	always_ff @(posedge Clk) begin
		if (reset || restart) begin
			tick_count <= '0;
		end else if (tick) begin
			tick_count <= '0;
		end else begin
			tick_count <= tick_count + 32'd1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// ping-pong sweep, turns around at both ends without a pause

	always_ff @(posedge Clk) begin
		if (reset || restart) begin
			angle <= '0;
			sweep_up <= 1'b1;
		end else if (tick && state == SWING) begin
			if (sweep_up) begin
				if (angle == ANGLE_MAX) begin
					angle <= angle - 4'd1;
					sweep_up <= 1'b0;
				end else begin
					angle <= angle + 4'd1;
				end
			end else begin
				if (angle == '0) begin
					angle <= angle + 4'd1;
					sweep_up <= 1'b1;
				end else begin
					angle <= angle - 4'd1;
				end
			end
		end
	end

	angle_in_range: assert property (@(posedge Clk) disable iff (reset || restart)
		angle <= ANGLE_MAX);

endmodule

`default_nettype wire

/* src/tail_position.sv */
`timescale 1ns/1ps
`default_nettype none

module tail_position import hook_pkg::*; (
	input  logic   Clk,
	input  logic   reset,
	input  logic   restart,
	input  angle_t angle,
	input  reach_t reach,
	output coord_t tail_x,
	output coord_t tail_y,
	output logic   at_bound
);

	// tail at rest for angle 0
	localparam coord_t REST_X = coord_t'(int'(HEAD_X) + int'(DIR_X[0]));
	localparam coord_t REST_Y = coord_t'(int'(HEAD_Y) + int'(DIR_Y[0]));

	logic signed [11:0] length;
	logic signed [15:0] offset_x;
	logic signed [15:0] offset_y;
	logic signed [15:0] next_x;
	logic signed [15:0] next_y;

	// string length is reach+1 direction steps
	always_comb begin
		length = $signed({2'b00, reach}) + 12'sd1;
		offset_x = length * DIR_X[angle];
		offset_y = length * DIR_Y[angle];
		next_x = $signed(16'(HEAD_X)) + offset_x;
		next_y = $signed(16'(HEAD_Y)) + offset_y;
	end

	always_ff @(posedge Clk) begin
		if (reset || restart) begin
			tail_x <= REST_X;
			tail_y <= REST_Y;
		end else begin
			tail_x <= coord_t'(next_x);
			tail_y <= coord_t'(next_y);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// play field edges, no top edge since the string only goes down

	assign at_bound = (tail_x <= BOUND_LEFT) || (tail_x >= BOUND_RIGHT)
		|| (tail_y >= BOUND_BOTTOM);

endmodule

`default_nettype wire

/* verif/tb_hook_model.svh */
`ifndef TB_HOOK_MODEL_SVH
`define TB_HOOK_MODEL_SVH

// string origin and play field
localparam int ORIGIN_X = 430;
localparam int ORIGIN_Y = 70;
localparam int FIELD_LEFT = 40;
localparam int FIELD_RIGHT = 620;
localparam int FIELD_BOTTOM = 460;

// tail step per reach unit, angle 0 points straight left
localparam int STEP_X [0:10] = '{-6, -6, -5, -4, -2, 0, 2, 4, 5, 6, 6};
localparam int STEP_Y [0:10] = '{0, 1, 2, 3, 4, 6, 4, 3, 2, 1, 0};

//////////////////////////////////////////////////////////////////////
// sweep, one position per tick over a 20 step round trip

function automatic int next_sweep_phase(int phase);
	return (phase + 1) % 20;
endfunction

function automatic int sweep_angle(int phase);
	if (phase <= 10) begin
		return phase;
	end else begin
		return 20 - phase;
	end
endfunction

//////////////////////////////////////////////////////////////////////
// tail and field

function automatic int expected_tail_x(int a, int r);
	return (ORIGIN_X + (r + 1) * STEP_X[a]) & 1023;
endfunction

function automatic int expected_tail_y(int a, int r);
	return (ORIGIN_Y + (r + 1) * STEP_Y[a]) & 1023;
endfunction

function automatic int outside_field(int x, int y);
	return (x <= FIELD_LEFT || x >= FIELD_RIGHT || y >= FIELD_BOTTOM) ? 1 : 0;
endfunction

//////////////////////////////////////////////////////////////////////
// catch classes and pull speed

function automatic weight_t weight_of_target(int t);
	case (t)
		0, 1, 6, 7, 10, 11: return WEIGHT_HEAVY;
		2, 3: return WEIGHT_MEDIUM;
		default: return WEIGHT_LIGHT;
	endcase
endfunction

// cycles between reach steps while pulling back
function automatic int retract_interval(weight_t w);
	case (w)
		WEIGHT_HEAVY: return TICK_PERIOD + 1;
		WEIGHT_MEDIUM: return TICK_PERIOD / 2 + 1;
		default: return TICK_PERIOD / 4 + 1;
	endcase
endfunction

`endif

/* verif/tb_hook_swing.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_hook_swing import hook_pkg::*; ();

	localparam int TICK_PERIOD = 16;
	localparam int TIMEOUT_CYCLES = 10000;
	localparam int EXTEND_INTERVAL = TICK_PERIOD / 2 + 1;

	`include "tb_hook_model.svh"

	logic                   Clk;
	logic                   reset;
	logic                   restart;
	logic                   extend;
	logic [NUM_TARGETS-1:0] catch_hit;
	logic [NUM_TARGETS-1:0] target_gone;
	hook_state_t            state;
	angle_t                 angle;
	reach_t                 reach;
	coord_t                 tail_x;
	coord_t                 tail_y;
	logic                   at_bound;

	// checker model state
	int cycle_count = 0;
	int tick_cnt = 0;
	int sweep_phase = 0;
	int angle_changes = 0;
	int prev_angle = 0;
	int prev_reach = 0;
	int exp_x;
	int exp_y;
	bit tick;
	hook_state_t prev_state = SWING;

	integer seed;
	int     target;

	hook_swing_top #(.TICK_PERIOD(TICK_PERIOD)) UUT (
		.Clk         (Clk),
		.reset       (reset),
		.restart     (restart),
		.extend      (extend),
		.catch_hit   (catch_hit),
		.target_gone (target_gone),
		.state       (state),
		.angle       (angle),
		.reach       (reach),
		.tail_x      (tail_x),
		.tail_y      (tail_y),
		.at_bound    (at_bound)
	);

	always #10 Clk = ~Clk;

	task automatic abort_run(string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic compare_value(string name, int got, int expected);
		assert (got == expected)
			else abort_run($sformatf("mismatch at %0t ns: %s is %0d, expected %0d",
				$time, name, got, expected));
	endtask

	//////////////////////////////////////////////////////////////////////
	// checker, runs just after every rising edge

	always @(posedge Clk) begin
		#1;
		cycle_count = cycle_count + 1;
		assert (cycle_count < TIMEOUT_CYCLES)
			else abort_run("timeout, the tests did not finish within the cycle limit");
		if (reset || restart) begin
			tick_cnt = 0;
			sweep_phase = 0;
			compare_value("state", int'(state), int'(SWING));
			compare_value("angle", int'(angle), 0);
			compare_value("reach", int'(reach), 0);
			compare_value("tail_x", int'(tail_x), expected_tail_x(0, 0));
			compare_value("tail_y", int'(tail_y), expected_tail_y(0, 0));
			compare_value("at_bound", int'(at_bound), 0);
		end else begin
			tick = (tick_cnt == TICK_PERIOD);
			tick_cnt = tick ? 0 : tick_cnt + 1;
			if (tick && prev_state == SWING) begin
				sweep_phase = next_sweep_phase(sweep_phase);
			end
			compare_value("angle", int'(angle), sweep_angle(sweep_phase));
			// tail lags angle and reach by one cycle
			exp_x = expected_tail_x(prev_angle, prev_reach);
			exp_y = expected_tail_y(prev_angle, prev_reach);
			compare_value("tail_x", int'(tail_x), exp_x);
			compare_value("tail_y", int'(tail_y), exp_y);
			compare_value("at_bound", int'(at_bound), outside_field(exp_x, exp_y));
			if (int'(angle) != prev_angle) begin
				angle_changes = angle_changes + 1;
			end
		end
		prev_angle = int'(angle);
		prev_reach = int'(reach);
		prev_state = state;
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus helpers, all entered on a falling edge

	task automatic wait_for_angle(int a);
		while (int'(angle) == a) @(negedge Clk);
		while (int'(angle) != a) @(negedge Clk);
	endtask

	task automatic fire();
		compare_value("state", int'(state), int'(SWING));
		extend = 1'b1;
		@(negedge Clk);
		compare_value("state", int'(state), int'(AIM));
		repeat (3) @(negedge Clk);
		compare_value("state", int'(state), int'(AIM));
		extend = 1'b0;
		@(negedge Clk);
		compare_value("state", int'(state), int'(EXTEND));
	endtask

	// follow reach while in one state, first step may come early in RETRACT
	task automatic watch_reach(hook_state_t phase, int interval, int delta, bit skip_first);
		int last_change;
		int prev;
		bit first;
		last_change = cycle_count;
		prev = int'(reach);
		first = 1'b1;
		while (state == phase) begin
			@(negedge Clk);
			if (int'(reach) != prev) begin
				compare_value("reach", int'(reach), prev + delta);
				if (!first || !skip_first) begin
					compare_value("reach interval", cycle_count - last_change, interval);
				end
				first = 1'b0;
				last_change = cycle_count;
				prev = int'(reach);
			end
		end
	endtask

	task automatic grab_target(int t);
		while (int'(reach) != 6) @(negedge Clk);
		catch_hit = 14'(1) << t;
		target_gone = 14'($random(seed)) & ~(14'(1) << t);
		@(negedge Clk);
		compare_value("state", int'(state), int'(RETRACT));
		catch_hit = '0;
		target_gone = '0;
		watch_reach(RETRACT, retract_interval(weight_of_target(t)), -1, 1'b1);
		compare_value("state", int'(state), int'(SWING));
		compare_value("reach", int'(reach), 0);
	endtask

	// a hit on a taken target must not stop the string
	task automatic ignore_gone_hit(int t);
		fire();
		while (int'(reach) != 3) @(negedge Clk);
		catch_hit = 14'(1) << t;
		target_gone = 14'(1) << t;
		repeat (2 * EXTEND_INTERVAL) begin
			@(negedge Clk);
			compare_value("state", int'(state), int'(EXTEND));
		end
		compare_value("reach", int'(reach), 5);
		catch_hit = '0;
		target_gone = '0;
		grab_target(t);
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequence

	initial begin
		Clk = 1'b0;
		reset = 1'b1;
		restart = 1'b0;
		extend = 1'b0;
		catch_hit = '0;
		target_gone = '0;
		seed = 32'hf6c6aae9;
		repeat (10) @(negedge Clk);
		reset = 1'b0;

		// two full sweeps with the button up
		while (angle_changes < 40) begin
			@(negedge Clk);
			compare_value("state", int'(state), int'(SWING));
		end

		// fire at angle 0, runs out to the left edge
		wait_for_angle(0);
		fire();
		watch_reach(EXTEND, EXTEND_INTERVAL, 1, 1'b0);
		compare_value("state", int'(state), int'(RETRACT));
		compare_value("reach", int'(reach), 64);
		compare_value("angle", int'(angle), 0);
		watch_reach(RETRACT, retract_interval(WEIGHT_NONE), -1, 1'b1);
		compare_value("state", int'(state), int'(SWING));

		repeat (4) begin
			target = $unsigned($random(seed)) % NUM_TARGETS;
			fire();
			grab_target(target);
		end

		target = $unsigned($random(seed)) % NUM_TARGETS;
		ignore_gone_hit(target);

		// restart in the middle of an extension
		fire();
		while (int'(reach) != 4) @(negedge Clk);
		restart = 1'b1;
		@(negedge Clk);
		restart = 1'b0;
		compare_value("state", int'(state), int'(SWING));
		compare_value("reach", int'(reach), 0);
		repeat (5) @(negedge Clk);

		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+verif
src/hook_pkg.sv
src/swing_timer.sv
src/grab_detector.sv
src/hook_fsm.sv
src/reach_counter.sv
src/tail_position.sv
src/hook_swing_top.sv
verif/tb_hook_swing.sv
